// File: Bender.yml
package:
  name: instr_decode

sources:
  - src/rv_isa_pkg.sv
  - src/decode_pkg.sv
  - src/imm_gen.sv
  - src/ctrl_decode.sv
  - src/id_ex_reg.sv
  - src/instr_decode_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_instr_decode.sv

// File: build.f
src/rv_isa_pkg.sv
src/decode_pkg.sv
src/imm_gen.sv
src/ctrl_decode.sv
src/id_ex_reg.sv
src/instr_decode_top.sv
+incdir+testbench
testbench/tb_instr_decode.sv

// File: src/ctrl_decode.sv
`default_nettype none
`timescale 1ns/1ps

module ctrl_decode (
    input  wire logic [rv_isa_pkg::XLEN-1:0] instr_i,
    output decode_pkg::decoded_t             dec_o,     // imm left at zero
    output decode_pkg::imm_fmt_e             imm_fmt_o
);

    import rv_isa_pkg::*;
    import decode_pkg::*;

    logic [OPC_W-1:0]      opcode;
    logic [FUNCT3_W-1:0]   funct3;
    logic                  alt;     // funct7 alternate bit
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign alt    = instr_i[FUNCT7_ALT_BIT];
    assign rs1    = instr_i[19:15];
    assign rs2    = instr_i[24:20];
    assign rd     = instr_i[11:7];

    // ALU group decode for OP and OP-IMM
    // SUB exists only in the register form, ADDI ignores bit 30
    function automatic alu_op_e alu_from_f3(
        input logic [FUNCT3_W-1:0] f3,
        input logic                alt_bit,
        input logic                reg_form
    );
        case (f3)
            F3_ADD_SUB: return (reg_form && alt_bit) ? ALU_SUB : ALU_ADD;
            F3_SLL:     return ALU_SLL;
            F3_SLT:     return ALU_SLT;
            F3_SLTU:    return ALU_SLTU;
            F3_XOR:     return ALU_XOR;
            F3_SRL_SRA: return alt_bit ? ALU_SRA : ALU_SRL;
            F3_OR:      return ALU_OR;
            default:    return ALU_AND;  // F3_AND, the last code
        endcase
    endfunction

    always_comb begin
        dec_o     = '0;        // Unknown, FENCE and SYSTEM stay all zero
        imm_fmt_o = FMT_NONE;

        case (opcode)
            OPC_LUI: begin
                dec_o.ctrl.data_origin = IMM_RS1;  // x0 + imm
                dec_o.ctrl.alu_op      = ALU_ADD;
                dec_o.ctrl.reg_w       = 1'b1;
                dec_o.rd_addr          = rd;
                dec_o.r1_addr          = '0;
                imm_fmt_o              = FMT_U;
            end
            OPC_AUIPC: begin
                dec_o.ctrl.data_origin = IMM_PC;   // PC + imm
                dec_o.ctrl.alu_op      = ALU_ADD;
                dec_o.ctrl.reg_w       = 1'b1;
                dec_o.rd_addr          = rd;
                imm_fmt_o              = FMT_U;
            end
            OPC_JAL: begin
                dec_o.ctrl.is_branch   = 1'b1;
                dec_o.ctrl.data_origin = IMM_PC;   // Target is PC relative
                dec_o.ctrl.alu_op      = ALU_ADD;
                dec_o.ctrl.reg_w       = 1'b1;     // Link register
                dec_o.rd_addr          = rd;
                imm_fmt_o              = FMT_J;
            end
            OPC_JALR: begin
                dec_o.ctrl.is_branch   = 1'b1;
                dec_o.ctrl.data_origin = IMM_RS1;  // Target is rs1 + imm
                dec_o.ctrl.alu_op      = ALU_ADD;
                dec_o.ctrl.reg_w       = 1'b1;
                dec_o.r1_addr          = rs1;
                dec_o.rd_addr          = rd;
                imm_fmt_o              = FMT_I;
            end
            OPC_BRANCH: begin
                // Compare rs1 with rs2, EX adds the offset to PC itself
                dec_o.ctrl.is_branch   = 1'b1;
                dec_o.ctrl.data_origin = REGS;
                dec_o.ctrl.alu_op      = ALU_SUB;  // Equality by subtraction
                dec_o.r1_addr          = rs1;
                dec_o.r2_addr          = rs2;
                imm_fmt_o              = FMT_B;
                case (funct3)
                    F3_BNE: dec_o.ctrl.br_op = BR_NE;
                    F3_BLT: begin
                        dec_o.ctrl.br_op  = BR_LT;
                        dec_o.ctrl.alu_op = ALU_SLT;
                    end
                    F3_BGE: begin
                        dec_o.ctrl.br_op  = BR_GE;
                        dec_o.ctrl.alu_op = ALU_SLT;
                    end
                    F3_BLTU: begin
                        dec_o.ctrl.br_op  = BR_LT;
                        dec_o.ctrl.alu_op = ALU_SLTU;
                    end
                    F3_BGEU: begin
                        dec_o.ctrl.br_op  = BR_GE;
                        dec_o.ctrl.alu_op = ALU_SLTU;
                    end
                    default: dec_o.ctrl.br_op = BR_EQ;  // BEQ and the reserved codes
                endcase
            end
            OPC_LOAD: begin
                dec_o.ctrl.is_load_store = 1'b1;
                dec_o.ctrl.reg_w         = 1'b1;
                dec_o.ctrl.alu_op        = ALU_ADD;  // Address = rs1 + offset
                dec_o.ctrl.data_origin   = IMM_RS1;
                dec_o.r1_addr            = rs1;
                dec_o.rd_addr            = rd;
                imm_fmt_o                = FMT_I;
                case (funct3)
                    F3_LH:   dec_o.ctrl.lis_op = LIS_LH;
                    F3_LW:   dec_o.ctrl.lis_op = LIS_LW;
                    F3_LBU:  dec_o.ctrl.lis_op = LIS_LBU;
                    F3_LHU:  dec_o.ctrl.lis_op = LIS_LHU;
                    default: dec_o.ctrl.lis_op = LIS_LB;  // LB and undefined widths
                endcase
            end
            OPC_STORE: begin
                dec_o.ctrl.is_load_store = 1'b1;
                dec_o.ctrl.mem_w         = 1'b1;
                dec_o.ctrl.alu_op        = ALU_ADD;
                dec_o.ctrl.data_origin   = IMM_RS1;
                dec_o.r1_addr            = rs1;     // Base
                dec_o.r2_addr            = rs2;     // Store data
                imm_fmt_o                = FMT_S;
                case (funct3)
                    F3_SB: begin
                        dec_o.ctrl.lis_op         = LIS_SB;
                        dec_o.ctrl.write_transfer = 4'b0001;
                    end
                    F3_SH: begin
                        dec_o.ctrl.lis_op         = LIS_SH;
                        dec_o.ctrl.write_transfer = 4'b0011;
                    end
                    F3_SW: begin
                        dec_o.ctrl.lis_op         = LIS_SW;
                        dec_o.ctrl.write_transfer = 4'b1111;
                    end
                    default: dec_o.ctrl.lis_op = LIS_LB;  // No bytes enabled
                endcase
            end
            OPC_OP_IMM: begin
                dec_o.ctrl.data_origin = IMM_RS1;
                dec_o.ctrl.alu_op      = alu_from_f3(funct3, alt, 1'b0);
                dec_o.ctrl.reg_w       = 1'b1;
                dec_o.r1_addr          = rs1;
                dec_o.rd_addr          = rd;
                imm_fmt_o              = FMT_I;
            end
            OPC_OP: begin
                dec_o.ctrl.data_origin = REGS;
                dec_o.ctrl.alu_op      = alu_from_f3(funct3, alt, 1'b1);
                dec_o.ctrl.reg_w       = 1'b1;
                dec_o.r1_addr          = rs1;
                dec_o.r2_addr          = rs2;
                dec_o.rd_addr          = rd;
            end
            default: ;
        endcase
    end

    // Control word consistency across all opcodes
    store_is_mem_a:  assert final (!dec_o.ctrl.mem_w || dec_o.ctrl.is_load_store);
    mask_on_store_a: assert final ((dec_o.ctrl.write_transfer == '0) || dec_o.ctrl.mem_w);
    store_no_wb_a:   assert final (!(dec_o.ctrl.mem_w && dec_o.ctrl.reg_w));

endmodule

`default_nettype wire

// File: src/decode_pkg.sv
package decode_pkg;

    // Store byte-enable width, one bit per byte of a word
    localparam int TRANSFER_W = 4;

    // Operation handed to the ALU
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,  // Also the compare for BEQ/BNE
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    // Load/store unit operation, loads first then stores
    typedef enum logic [2:0] {
        LIS_LB  = 3'd0,
        LIS_LH  = 3'd1,
        LIS_LW  = 3'd2,
        LIS_LBU = 3'd3,
        LIS_LHU = 3'd4,
        LIS_SB  = 3'd5,
        LIS_SH  = 3'd6,
        LIS_SW  = 3'd7
    } lis_op_e;

    // Branch condition evaluated on the ALU result
    typedef enum logic [1:0] {
        BR_EQ = 2'd0,
        BR_NE = 2'd1,
        BR_LT = 2'd2,
        BR_GE = 2'd3
    } br_op_e;

    // Where the execution unit takes its operands from
    typedef enum logic [1:0] {
        REGS    = 2'd0,  // rs1 and rs2
        IMM_RS1 = 2'd1,  // rs1 and immediate
        IMM_PC  = 2'd2   // PC and immediate
    } data_origin_e;

    // Immediate layout selected by the decoder
    typedef enum logic [2:0] {
        FMT_NONE = 3'd0,
        FMT_I    = 3'd1,
        FMT_S    = 3'd2,
        FMT_B    = 3'd3,
        FMT_U    = 3'd4,
        FMT_J    = 3'd5
    } imm_fmt_e;

    // Execution-unit controls
    typedef struct packed {
        alu_op_e                 alu_op;
        lis_op_e                 lis_op;
        br_op_e                  br_op;
        data_origin_e            data_origin;
        logic                    is_branch;      // JAL, JALR and conditional branches
        logic                    is_load_store;
        logic                    mem_w;          // Store
        logic                    reg_w;          // Write back to rd
        logic [TRANSFER_W-1:0]   write_transfer; // Byte mask of a store
    } ctrl_t;

    // Full decoded instruction as carried into EX
    typedef struct packed {
        ctrl_t                              ctrl;
        logic [rv_isa_pkg::REG_ADDR_W-1:0]  r1_addr;
        logic [rv_isa_pkg::REG_ADDR_W-1:0]  r2_addr;
        logic [rv_isa_pkg::REG_ADDR_W-1:0]  rd_addr;
        logic [rv_isa_pkg::XLEN-1:0]        imm;
    } decoded_t;

endpackage

// File: src/id_ex_reg.sv
`default_nettype none
`timescale 1ns/1ps

module id_ex_reg (
    input  wire logic                 clk_i,
    input  wire logic                 rst_i,
    input  wire logic                 valid_i,
    input  wire decode_pkg::decoded_t dec_i,
    output logic                      valid_o,
    output decode_pkg::decoded_t      dec_o
);

    import decode_pkg::*;

    logic     valid_q;
    decoded_t dec_q;    // Held across bubbles

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= 1'b0;
            dec_q   <= '0;
        end else begin
            valid_q <= valid_i;  // Bubble when no strobe
            if (valid_i) begin
                dec_q <= dec_i;
            end
        end
    end

    assign valid_o = valid_q;
    assign dec_o   = dec_q;

    // Nothing leaves the stage right after reset
    valid_low_after_rst_a: assert property (
        @(posedge clk_i) rst_i |=> !valid_o
    );

    // A bubble must not disturb the payload seen by EX
    payload_held_a: assert property (
        @(posedge clk_i) disable iff (rst_i) !valid_i |=> $stable(dec_o)
    );

endmodule

`default_nettype wire

// File: src/imm_gen.sv
`default_nettype none
`timescale 1ns/1ps

module imm_gen (
    input  wire logic [rv_isa_pkg::XLEN-1:0] instr_i,
    input  wire decode_pkg::imm_fmt_e        imm_fmt_i,
    output logic [rv_isa_pkg::XLEN-1:0]      imm_o
);

    import rv_isa_pkg::*;
    import decode_pkg::*;

    logic             sign;     // Bit 31 is the sign in every format
    logic [XLEN-1:0]  imm_i;
    logic [XLEN-1:0]  imm_s;
    logic [XLEN-1:0]  imm_b;
    logic [XLEN-1:0]  imm_u;
    logic [XLEN-1:0]  imm_j;

    assign sign = instr_i[31];

    // Loads, JALR and OP-IMM
    assign imm_i = {{(XLEN-12){sign}}, instr_i[31:20]};

    // Stores, offset split around rs1/rs2
    assign imm_s = {{(XLEN-12){sign}}, instr_i[31:25], instr_i[11:7]};

    // Branch offset in halfwords, bit 0 always zero
    assign imm_b = {{(XLEN-13){sign}},
                    instr_i[31], instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};

    // Upper immediate, low twelve bits cleared
    assign imm_u = {instr_i[31:12], 12'b0};

    // JAL offset, scrambled as in the ISA
    assign imm_j = {{(XLEN-21){sign}},
                    instr_i[31], instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

    always_comb begin
        case (imm_fmt_i)
            FMT_I:   imm_o = imm_i;
            FMT_S:   imm_o = imm_s;
            FMT_B:   imm_o = imm_b;
            FMT_U:   imm_o = imm_u;
            FMT_J:   imm_o = imm_j;
            default: imm_o = '0;  // FMT_NONE and spare codes
        endcase
    end

endmodule

`default_nettype wire

// File: src/instr_decode_top.sv
`default_nettype none
`timescale 1ns/1ps

module instr_decode_top (
    input  wire logic                        clk_i,
    input  wire logic                        rst_i,
    input  wire logic                        instr_valid_i,
    input  wire logic [rv_isa_pkg::XLEN-1:0] instr_i,
    output logic                             valid_o,
    output decode_pkg::decoded_t             decoded_o
);

    import rv_isa_pkg::*;
    import decode_pkg::*;

    decoded_t        dec_ctrl;   // Controls and addresses, imm still zero
    decoded_t        dec_full;
    imm_fmt_e        imm_fmt;
    logic [XLEN-1:0] imm;

    ctrl_decode ctrl_decode_inst (
        .instr_i   (instr_i),
        .dec_o     (dec_ctrl),
        .imm_fmt_o (imm_fmt)
    );

    imm_gen imm_gen_inst (
        .instr_i   (instr_i),
        .imm_fmt_i (imm_fmt),
        .imm_o     (imm)
    );

    // Splice the immediate into the decoded word
    assign dec_full = '{ctrl:    dec_ctrl.ctrl,
                        r1_addr: dec_ctrl.r1_addr,
                        r2_addr: dec_ctrl.r2_addr,
                        rd_addr: dec_ctrl.rd_addr,
                        imm:     imm};

    id_ex_reg id_ex_reg_inst (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .valid_i (instr_valid_i),
        .dec_i   (dec_full),
        .valid_o (valid_o),
        .dec_o   (decoded_o)
    );

endmodule

`default_nettype wire

// File: src/rv_isa_pkg.sv
package rv_isa_pkg;

    // Datapath and instruction width
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;   // x0..x31
    localparam int OPC_W      = 7;
    localparam int FUNCT3_W   = 3;

    // Major opcodes, bits 6:0 of the word
    localparam logic [OPC_W-1:0] OPC_LUI    = 7'b0110111;
    localparam logic [OPC_W-1:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [OPC_W-1:0] OPC_JAL    = 7'b1101111;
    localparam logic [OPC_W-1:0] OPC_JALR   = 7'b1100111;
    localparam logic [OPC_W-1:0] OPC_BRANCH = 7'b1100011;
    localparam logic [OPC_W-1:0] OPC_LOAD   = 7'b0000011;
    localparam logic [OPC_W-1:0] OPC_STORE  = 7'b0100011;
    localparam logic [OPC_W-1:0] OPC_OP_IMM = 7'b0010011;  // Register-immediate ALU
    localparam logic [OPC_W-1:0] OPC_OP     = 7'b0110011;  // Register-register ALU

    // Conditional branches
    localparam logic [FUNCT3_W-1:0] F3_BEQ  = 3'b000;
    localparam logic [FUNCT3_W-1:0] F3_BNE  = 3'b001;
    localparam logic [FUNCT3_W-1:0] F3_BLT  = 3'b100;
    localparam logic [FUNCT3_W-1:0] F3_BGE  = 3'b101;
    localparam logic [FUNCT3_W-1:0] F3_BLTU = 3'b110;
    localparam logic [FUNCT3_W-1:0] F3_BGEU = 3'b111;

    // Loads, 011/110/111 are not defined in RV32I
    localparam logic [FUNCT3_W-1:0] F3_LB  = 3'b000;
    localparam logic [FUNCT3_W-1:0] F3_LH  = 3'b001;
    localparam logic [FUNCT3_W-1:0] F3_LW  = 3'b010;
    localparam logic [FUNCT3_W-1:0] F3_LBU = 3'b100;
    localparam logic [FUNCT3_W-1:0] F3_LHU = 3'b101;

    // Stores
    localparam logic [FUNCT3_W-1:0] F3_SB = 3'b000;
    localparam logic [FUNCT3_W-1:0] F3_SH = 3'b001;
    localparam logic [FUNCT3_W-1:0] F3_SW = 3'b010;

    // ALU group, shared by OP and OP-IMM
    localparam logic [FUNCT3_W-1:0] F3_ADD_SUB = 3'b000;
    localparam logic [FUNCT3_W-1:0] F3_SLL     = 3'b001;
    localparam logic [FUNCT3_W-1:0] F3_SLT     = 3'b010;
    localparam logic [FUNCT3_W-1:0] F3_SLTU    = 3'b011;
    localparam logic [FUNCT3_W-1:0] F3_XOR     = 3'b100;
    localparam logic [FUNCT3_W-1:0] F3_SRL_SRA = 3'b101;
    localparam logic [FUNCT3_W-1:0] F3_OR      = 3'b110;
    localparam logic [FUNCT3_W-1:0] F3_AND     = 3'b111;

    // funct7[5] in the word, picks SUB over ADD and SRA over SRL
    localparam int FUNCT7_ALT_BIT = 30;

endpackage

// File: testbench/decode_ref.svh
// ALU codes run ADD SUB SLL SLT SLTU XOR SRL SRA OR AND
function automatic alu_op_e arith_alu(input logic [2:0] f3, input logic alt, input logic is_reg);
    int code;
    code = int'(f3) + (f3 != 3'd0) + (f3 >= 3'd6);  // Skip the SUB and SRA slots
    if (alt && (f3 == 3'd5 || (f3 == 3'd0 && is_reg)))
        code = code + 1;                            // Alternate form is one slot up
    return alu_op_e'(code);
endfunction

function automatic decoded_t ref_decode(input logic [31:0] w);
    decoded_t   d;
    logic [2:0] f3;
    f3 = w[14:12];
    d  = '0;  // ADD, LB, EQ and REGS are all code zero
    case (w[6:0])
        OPC_LUI: begin
            d.ctrl.data_origin = IMM_RS1;
            d.imm              = {w[31:12], 12'h000};
        end
        OPC_AUIPC: begin
            d.ctrl.data_origin = IMM_PC;
            d.imm              = {w[31:12], 12'h000};
        end
        OPC_JAL: begin
            d.ctrl.is_branch   = 1'b1;
            d.ctrl.data_origin = IMM_PC;
            d.imm              = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        end
        OPC_JALR: begin
            d.ctrl.is_branch   = 1'b1;
            d.ctrl.data_origin = IMM_RS1;
            d.r1_addr          = w[19:15];
            d.imm              = {{20{w[31]}}, w[31:20]};
        end
        OPC_BRANCH: begin
            d.ctrl.is_branch = 1'b1;
            d.ctrl.alu_op    = ALU_SUB;
            d.r1_addr        = w[19:15];
            d.r2_addr        = w[24:20];
            d.imm            = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            if (f3[2]) begin  // Ordered compares, f3[1] marks unsigned
                d.ctrl.br_op  = br_op_e'({1'b1, f3[0]});
                d.ctrl.alu_op = f3[1] ? ALU_SLTU : ALU_SLT;
            end else if (!f3[1])
                d.ctrl.br_op = br_op_e'({1'b0, f3[0]});
        end
        OPC_LOAD: begin
            d.ctrl.is_load_store = 1'b1;
            d.ctrl.data_origin   = IMM_RS1;
            d.r1_addr            = w[19:15];
            d.imm                = {{20{w[31]}}, w[31:20]};
            if (f3[2] && !f3[1])
                d.ctrl.lis_op = lis_op_e'(f3 - 3'd1);  // LBU, LHU
            else if (f3 <= 3'd2)
                d.ctrl.lis_op = lis_op_e'(f3);         // LB, LH, LW
        end
        OPC_STORE: begin
            d.ctrl.is_load_store = 1'b1;
            d.ctrl.mem_w         = 1'b1;
            d.ctrl.data_origin   = IMM_RS1;
            d.r1_addr            = w[19:15];
            d.r2_addr            = w[24:20];
            d.imm                = {{20{w[31]}}, w[31:25], w[11:7]};
            if (f3 <= 3'd2) begin  // 1, 2 or 4 bytes from lane 0
                d.ctrl.lis_op         = lis_op_e'(3'd5 + f3);
                d.ctrl.write_transfer = 4'((5'd1 << (3'd1 << f3)) - 5'd1);
            end
        end
        OPC_OP_IMM: begin
            d.ctrl.data_origin = IMM_RS1;
            d.ctrl.alu_op      = arith_alu(f3, w[30], 1'b0);
            d.r1_addr          = w[19:15];
            d.imm              = {{20{w[31]}}, w[31:20]};
        end
        OPC_OP: begin
            d.ctrl.alu_op = arith_alu(f3, w[30], 1'b1);
            d.r1_addr     = w[19:15];
            d.r2_addr     = w[24:20];
        end
        default: ;
    endcase
    // Everything but branches and stores writes rd
    d.ctrl.reg_w = (w[6:0] inside {OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR,
                                   OPC_LOAD, OPC_OP_IMM, OPC_OP});
    if (d.ctrl.reg_w)
        d.rd_addr = w[11:7];
    return d;
endfunction

// File: testbench/tb_instr_decode.sv
`timescale 1ns/1ps

module tb_instr_decode;

    import rv_isa_pkg::*;
    import decode_pkg::*;

    localparam int RST_CYCLES = 10;
    localparam int N_DIRECTED = 72;
    localparam int N_RANDOM   = 2000;
    // Each random word may be followed by one gap cycle
    localparam int MAX_CYCLES = RST_CYCLES + N_DIRECTED + 2 * N_RANDOM + 100;

    logic            clk_i         = 1'b0;
    logic            rst_i         = 1'b1;
    logic            instr_valid_i = 1'b0;
    logic [XLEN-1:0] instr_i       = '0;
    logic            valid_o;
    decoded_t        decoded_o;

    logic [31:0] rng_state  = 32'h192b_5e7e;
    logic        exp_valid  = 1'b0;
    decoded_t    exp_dec    = '0;
    logic [31:0] last_instr = '0;  // Word behind exp_dec
    int          cycle_cnt  = 0;

    `include "decode_ref.svh"

    instr_decode_top instr_decode_top_inst (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .valid_o       (valid_o),
        .decoded_o     (decoded_o)
    );

    always #20 clk_i = ~clk_i;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rand_word();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Kept opcodes first, then FENCE and SYSTEM
    function automatic logic [6:0] pick_opcode(input int sel);
        case (sel)
            0:       return OPC_LUI;
            1:       return OPC_AUIPC;
            2:       return OPC_JAL;
            3:       return OPC_JALR;
            4:       return OPC_BRANCH;
            5:       return OPC_LOAD;
            6:       return OPC_STORE;
            7:       return OPC_OP_IMM;
            8:       return OPC_OP;
            9:       return 7'b0001111;
            default: return 7'b1110011;
        endcase
    endfunction

    task automatic expect_equal(input logic [$bits(decoded_t)-1:0] got,
                                input logic [$bits(decoded_t)-1:0] exp,
                                input string what);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "Decode output mismatch");
        end
    endtask

    task automatic send_word(input logic [31:0] w);
        instr_valid_i = 1'b1;
        instr_i       = w;
        @(posedge clk_i);
        #2;
    endtask

    // Random word with the decode fields forced
    task automatic send_fields(input logic [6:0] opc, input logic [2:0] f3,
                               input logic alt, input logic sgn);
        logic [31:0] w;
        w        = rand_word();
        w[6:0]   = opc;
        w[14:12] = f3;
        w[30]    = alt;
        w[31]    = sgn;  // Sign of every immediate
        send_word(w);
    endtask

    task automatic idle_cycles(input int n);
        instr_valid_i = 1'b0;
        instr_i       = rand_word();  // Junk, must not be loaded
        repeat (n) begin
            @(posedge clk_i);
            #2;
        end
    endtask

    // Expected register contents, one edge behind the inputs
    always @(posedge clk_i) begin
        if (rst_i) begin
            exp_valid <= 1'b0;
            exp_dec   <= '0;
        end else begin
            exp_valid <= instr_valid_i;
            if (instr_valid_i) begin
                exp_dec    <= ref_decode(instr_i);
                last_instr <= instr_i;
            end
        end
    end

    always @(negedge clk_i) begin  // Outputs settled mid cycle
        expect_equal(valid_o, exp_valid, "valid_o");
        expect_equal(decoded_o, exp_dec, $sformatf("decoded_o for word %h", last_instr));
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout, test did not finish within %0d cycles", MAX_CYCLES);
            $display("ERRORS FOUND");
            $fatal(1, "Simulation timeout");
        end
    end

    initial begin
        logic [31:0] w;
        logic [31:0] sel;
        repeat (RST_CYCLES) @(posedge clk_i);
        #2;
        rst_i = 1'b0;
        idle_cycles(3);  // Reset values hold until the first strobe
        for (int k = 0; k < 32; k++) begin  // OP and OP-IMM, all funct3, both alt
            send_fields(k[4] ? OPC_OP : OPC_OP_IMM, k[2:0], k[3], k[0]);
        end
        for (int k = 0; k < 16; k++) begin  // Loads and stores, unknown widths too
            send_fields(k[3] ? OPC_STORE : OPC_LOAD, k[2:0], k[2], k[0] ^ k[1]);
        end
        for (int k = 0; k < 16; k++) begin
            send_fields(OPC_BRANCH, k[2:0], k[1], k[3]);
        end
        for (int k = 0; k < 8; k++) begin  // LUI AUIPC JAL JALR, both signs
            send_fields(pick_opcode(k[1:0]), k[2:0], k[0], k[2]);
        end
        idle_cycles(2);
        for (int n = 0; n < N_RANDOM; n++) begin
            w   = rand_word();
            sel = rand_word();
            if (sel[2:0] != 3'd0) begin  // One in eight keeps a random opcode
                w[6:0] = pick_opcode(int'(sel[31:8] % 11));
            end
            send_word(w);
            if (sel[5:4] == 2'b00) begin
                idle_cycles(1);
            end
        end
        idle_cycles(2);  // Last word through the register
        $display("NO ERRORS");
        $finish;
    end

endmodule
